// ==== verification/csr_stimulus.txt ====
# A addr mode src priv illegal rdata | B addr mode src priv illegal | T epc cause irq priv
# R epc priv | V irq cause tvec | I lines pending | N retires | W cycles | C | X count start
# Write, set and clear on mtvec.
A 305 1 00000100 3 0 00000000
A 305 2 00000000 3 0 00000100
A 305 2 00000001 3 0 00000100
A 305 3 00000000 3 0 00000101
# Write, set and clear on mscratch.
A 340 1 A5A50F0F 3 0 00000000
A 340 2 000000F0 3 0 A5A50F0F
A 340 3 A5A50000 3 0 A5A50FFF
A 340 3 00000000 3 0 00000FFF
A 340 2 00000000 3 0 00000FFF
# Legality.
A 7C0 2 00000000 3 1 00000000
A 300 2 00000000 0 1 00000000
B B00 1 00000000 3 0
A C00 1 12345678 3 1 00000000
A C00 2 00000000 0 0 00000001
A 344 1 00000888 3 1 00000000
A 344 2 00000000 3 0 00000000
# Interrupt trap from user, vectored mtvec.
A 300 1 00000008 3 0 00000000
T 80000040 0B 1 0
A 341 2 00000000 3 0 80000040
A 342 2 00000000 3 0 8000000B
A 300 2 00000000 3 0 00000080
V 1 0B 0000012C
V 0 0B 00000100
R 80000040 0
A 300 2 00000000 3 0 00000088
# Exception trap from machine, then direct mtvec.
T 00001000 02 0 3
A 341 2 00000000 3 0 00001000
A 342 2 00000000 3 0 00000002
A 300 2 00000000 3 0 00001880
R 00001000 3
A 300 2 00000000 3 0 00000088
A 305 3 00000001 3 0 00000101
V 1 0B 00000100
# Interrupt pending and mip mirror.
I 2 0
A 344 2 00000000 3 0 00000080
A 304 1 00000080 3 0 00000000
I 2 1
I 5 0
A 344 2 00000000 3 0 00000808
A 304 2 00000800 3 0 00000080
I 5 1
A 300 3 00000008 3 0 00000088
I 5 0
I 0 0
# Counters.
N 5
A B02 2 00000000 3 0 00000005
N 3
A C02 2 00000000 0 0 00000008
C
W 4
# Random mscratch round trip.
X 10 00000FFF

// ==== verilog.f ====
+incdir+source
source/csr_pkg.sv
source/csr_if.sv
source/csr_sel_enc.sv
source/csr_overlay.sv
source/csr_access_unit.sv
source/csr_machine_bank.sv
source/csr_counter_bank.sv
source/csr_unit.sv
verification/csr_tb_clock.sv
verification/csr_unit_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --assert -f verilog.f --top-module csr_unit_tb -o Vcsr_unit_tb
	./obj_dir/Vcsr_unit_tb | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	verilator --lint-only -Wall -f verilog.f --top-module csr_unit_tb

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/csr_unit_tb.sv ====
// CSR subsystem testbench
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_unit_tb;

    // Cycles allowed for any single wait.
    localparam int resp_timeout  = 16;
    localparam int reset_timeout = 32;
    localparam logic [15:0] lfsr_seed = 16'd18874;

    logic                clk;
    logic                rst_n;
    logic                req_valid;
    csr_pkg::csr_addr_t  req_addr;
    csr_pkg::csr_wmode_t req_wmode;
    csr_pkg::csr_word_t  req_src;
    csr_pkg::csr_priv_t  cur_priv;
    logic                resp_valid;
    logic                resp_illegal;
    csr_pkg::csr_word_t  resp_rdata;
    logic                trap;
    logic                is_irq;
    csr_pkg::csr_cause_t cause;
    csr_pkg::csr_word_t  epc;
    logic                mret;
    logic                retire;
    logic [2:0]          irq_lines;
    csr_pkg::csr_word_t  tvec;
    csr_pkg::csr_word_t  ret_epc;
    csr_pkg::csr_priv_t  ret_priv;
    logic                irq_pending;

    // Stimulus file handle and parse fields.
    int                  fd;
    int                  nread;
    logic [7:0]          cmd;
    logic [31:0]         v1, v2, v3, v4, v5, v6;
    logic [15:0]         lfsr_state;

    csr_tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    csr_unit uut (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_addr(req_addr), .req_wmode(req_wmode),
        .req_src(req_src), .cur_priv(cur_priv),
        .resp_valid(resp_valid), .resp_illegal(resp_illegal), .resp_rdata(resp_rdata),
        .trap(trap), .is_irq(is_irq), .cause(cause), .epc(epc), .mret(mret),
        .retire(retire), .irq_lines(irq_lines),
        .tvec(tvec), .ret_epc(ret_epc), .ret_priv(ret_priv), .irq_pending(irq_pending)
    );

    // Print the reason and end the run.
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_word(input csr_pkg::csr_word_t got, input csr_pkg::csr_word_t exp,
                              input string what);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL %0t ns: %s is %h, expected %h",
                                        $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL %0t ns: %s is %b, expected %b",
                                        $time, what, got, exp));
    endtask

    task automatic check_priv(input csr_pkg::csr_priv_t got, input csr_pkg::csr_priv_t exp,
                              input string what);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL %0t ns: %s is %0d, expected %0d",
                                        $time, what, got, exp));
    endtask

    // Fibonacci LFSR with taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    // Bounded wait on falling edges for the response strobe.
    task automatic wait_for_response(input string what);
        int cycles;
        cycles = 0;
        while (!resp_valid) begin
            if (cycles >= resp_timeout)
                stop_with_failure($sformatf("No response within %0d cycles for %s",
                                            resp_timeout, what));
            @(negedge clk);
            cycles++;
        end
        // The response is due one clock after sampling.
        if (cycles != 0)
            stop_with_failure($sformatf("FAIL %0t ns: response for %s came %0d cycles late",
                                        $time, what, cycles));
    endtask

    // One request checked against the old value and legality.
    task automatic run_access(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_wmode_t wmode,
                              input csr_pkg::csr_word_t src, input csr_pkg::csr_priv_t priv,
                              input logic exp_illegal, input logic check_data,
                              input csr_pkg::csr_word_t exp_rdata);
        req_valid = 1'b1;
        req_addr  = addr;
        req_wmode = wmode;
        req_src   = src;
        cur_priv  = priv;
        @(negedge clk);
        req_valid = 1'b0;
        wait_for_response($sformatf("access to %h", addr));
        check_flag(resp_illegal, exp_illegal, $sformatf("illegal flag of access to %h", addr));
        if (check_data)
            check_word(resp_rdata, exp_rdata, $sformatf("read data of access to %h", addr));
    endtask

    // Trap strobe for one cycle.
    task automatic pulse_trap(input csr_pkg::csr_word_t pc, input csr_pkg::csr_cause_t code,
                              input logic irq, input csr_pkg::csr_priv_t priv);
        trap     = 1'b1;
        epc      = pc;
        cause    = code;
        is_irq   = irq;
        cur_priv = priv;
        @(negedge clk);
        trap = 1'b0;
    endtask

    // Return target is checked before the mret strobe.
    task automatic return_from_trap(input csr_pkg::csr_word_t exp_epc,
                                    input csr_pkg::csr_priv_t exp_priv);
        check_word(ret_epc, exp_epc, "ret_epc");
        check_priv(ret_priv, exp_priv, "ret_priv");
        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
    endtask

    task automatic check_handler(input logic irq, input csr_pkg::csr_cause_t code,
                                 input csr_pkg::csr_word_t exp);
        is_irq = irq;
        cause  = code;
        @(negedge clk);
        check_word(tvec, exp, $sformatf("tvec for irq %b cause %h", irq, code));
    endtask

    task automatic apply_irq_lines(input logic [2:0] lines, input logic exp_pending);
        irq_lines = lines;
        @(negedge clk);
        check_flag(irq_pending, exp_pending, $sformatf("irq_pending with lines %b", lines));
    endtask

    // Retire strobes on consecutive cycles.
    task automatic pulse_retire(input int count);
        for (int i = 0; i < count; i++) begin
            retire = 1'b1;
            @(negedge clk);
        end
        retire = 1'b0;
    endtask

    // No response may show while no request is sampled.
    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            check_flag(resp_valid, 1'b0, "resp_valid in an idle cycle");
        end
    endtask

    // Back to back reads one cycle apart.
    task automatic read_mcycle_pair();
        csr_pkg::csr_word_t first;
        req_valid = 1'b1;
        req_addr  = `CSR_ADDR_MCYCLE;
        req_wmode = csr_pkg::wmode_set;
        req_src   = '0;
        cur_priv  = csr_pkg::priv_machine;
        @(negedge clk);
        wait_for_response("first mcycle read");
        check_flag(resp_illegal, 1'b0, "illegal flag of first mcycle read");
        first = resp_rdata;
        @(negedge clk);
        req_valid = 1'b0;
        wait_for_response("second mcycle read");
        check_word(resp_rdata, first + 32'd1, "second mcycle read");
    endtask

    // Random words through mscratch.
    task automatic random_roundtrip(input int count, input csr_pkg::csr_word_t start);
        csr_pkg::csr_word_t prev;
        csr_pkg::csr_word_t word;
        prev = start;
        word = '0;
        for (int i = 0; i < count; i++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr_state = lfsr_next(lfsr_state);
                word = {word[30:0], lfsr_state[0]};
            end
            run_access(`CSR_ADDR_MSCRATCH, csr_pkg::wmode_write, word,
                       csr_pkg::priv_machine, 1'b0, 1'b1, prev);
            run_access(`CSR_ADDR_MSCRATCH, csr_pkg::wmode_set, '0,
                       csr_pkg::priv_machine, 1'b0, 1'b1, word);
            prev = word;
        end
    endtask

    task automatic skip_line();
        int ch;
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1)
            ch = $fgetc(fd);
    endtask

    task automatic expect_fields(input int got, input int want);
        if (got != want)
            stop_with_failure($sformatf("Stimulus line for command %c has %0d fields, needs %0d",
                                        cmd, got, want));
    endtask

    // One stimulus line.
    task automatic run_command();
        case (cmd)
            "#": skip_line();
            "A", "B": begin
                nread = $fscanf(fd, "%h %h %h %h %h", v1, v2, v3, v4, v5);
                expect_fields(nread, 5);
                v6 = '0;
                // B lines have no read data column.
                if (cmd == "A") begin
                    nread = $fscanf(fd, "%h", v6);
                    expect_fields(nread, 1);
                end
                run_access(v1[11:0], csr_pkg::csr_wmode_t'(v2[1:0]), v3,
                           csr_pkg::csr_priv_t'(v4[1:0]), v5[0], cmd == "A", v6);
            end
            "T": begin
                nread = $fscanf(fd, "%h %h %h %h", v1, v2, v3, v4);
                expect_fields(nread, 4);
                pulse_trap(v1, v2[4:0], v3[0], csr_pkg::csr_priv_t'(v4[1:0]));
            end
            "R": begin
                nread = $fscanf(fd, "%h %h", v1, v2);
                expect_fields(nread, 2);
                return_from_trap(v1, csr_pkg::csr_priv_t'(v2[1:0]));
            end
            "V": begin
                nread = $fscanf(fd, "%h %h %h", v1, v2, v3);
                expect_fields(nread, 3);
                check_handler(v1[0], v2[4:0], v3);
            end
            "I": begin
                nread = $fscanf(fd, "%h %h", v1, v2);
                expect_fields(nread, 2);
                apply_irq_lines(v1[2:0], v2[0]);
            end
            "N": begin
                nread = $fscanf(fd, "%h", v1);
                expect_fields(nread, 1);
                pulse_retire(int'(v1));
            end
            "W": begin
                nread = $fscanf(fd, "%h", v1);
                expect_fields(nread, 1);
                idle_cycles(int'(v1));
            end
            "C": read_mcycle_pair();
            "X": begin
                nread = $fscanf(fd, "%h %h", v1, v2);
                expect_fields(nread, 2);
                random_roundtrip(int'(v1), v2);
            end
            default: stop_with_failure($sformatf("Unknown stimulus command %c", cmd));
        endcase
    endtask

    initial begin
        int cycles;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_wmode  = csr_pkg::wmode_write;
        req_src    = '0;
        cur_priv   = csr_pkg::priv_machine;
        trap       = 1'b0;
        is_irq     = 1'b0;
        cause      = '0;
        epc        = '0;
        mret       = 1'b0;
        retire     = 1'b0;
        irq_lines  = '0;
        lfsr_state = lfsr_seed;

        // Wait for reset release.
        @(negedge clk);
        cycles = 0;
        while (!rst_n) begin
            if (cycles >= reset_timeout)
                stop_with_failure("Reset was never released");
            @(negedge clk);
            cycles++;
        end

        fd = $fopen("verification/csr_stimulus.txt", "r");
        if (fd == 0)
            stop_with_failure("Cannot open verification/csr_stimulus.txt");

        // All commands start and end on a falling edge.
        while ($fscanf(fd, " %c", cmd) == 1)
            run_command();
        $fclose(fd);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== verification/csr_tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/100ps

module csr_tb_clock #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    // Free running clock, 40 ns period.
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Reset held low for eight rising edges.
    // Released on a falling edge like every other input.
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== source/csr_unit.sv ====
// CSR subsystem top level
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_unit (
    input  logic                clk,
    input  logic                rst_n,
    // CSR instruction request.
    input  logic                req_valid,
    input  csr_pkg::csr_addr_t  req_addr,
    input  csr_pkg::csr_wmode_t req_wmode,
    input  csr_pkg::csr_word_t  req_src,
    input  csr_pkg::csr_priv_t  cur_priv,
    // Response, one cycle later.
    output logic                resp_valid,
    output logic                resp_illegal,
    output csr_pkg::csr_word_t  resp_rdata,
    // Trap and return events.
    input  logic                trap,
    input  logic                is_irq,
    input  csr_pkg::csr_cause_t cause,
    input  csr_pkg::csr_word_t  epc,
    input  logic                mret,
    input  logic                retire,
    input  logic [2:0]          irq_lines,
    output csr_pkg::csr_word_t  tvec,
    output csr_pkg::csr_word_t  ret_epc,
    output csr_pkg::csr_priv_t  ret_priv,
    output logic                irq_pending
);

    // Unit side bus and one bus per bank.
    csr_if      cpu_bus ();
    csr_if      bank_bus [`CSR_NUM_BANKS] ();
    csr_trap_if trap_bus ();

    // Flush on any change of control flow.
    logic flush;
    assign flush = trap | mret;

    // Core side of the trap interface.
    assign trap_bus.trap     = trap;
    assign trap_bus.is_irq   = is_irq;
    assign trap_bus.cause    = cause;
    assign trap_bus.epc      = epc;
    assign trap_bus.mret     = mret;
    assign trap_bus.cur_priv = cur_priv;
    assign tvec              = trap_bus.tvec;
    assign ret_epc           = trap_bus.ret_epc;
    assign ret_priv          = trap_bus.ret_priv;
    assign irq_pending       = trap_bus.irq_pending;

    csr_access_unit u_access (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_addr(req_addr), .req_wmode(req_wmode),
        .req_src(req_src), .cur_priv(cur_priv), .flush(flush),
        .resp_valid(resp_valid), .resp_illegal(resp_illegal), .resp_rdata(resp_rdata),
        .bus(cpu_bus)
    );

    csr_overlay #(.banks(`CSR_NUM_BANKS)) u_overlay (
        .clk(clk), .up(cpu_bus), .down(bank_bus)
    );

    // Bank 0 holds the trap registers.
    csr_machine_bank u_machine (
        .clk(clk), .rst_n(rst_n), .irq_lines(irq_lines),
        .bus(bank_bus[0]), .trap(trap_bus)
    );

    // Bank 1 holds the counters.
    csr_counter_bank u_counter (
        .clk(clk), .rst_n(rst_n), .retire(retire), .bus(bank_bus[1])
    );

endmodule

// ==== source/csr_counter_bank.sv ====
// Cycle and instret counters
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_counter_bank (
    input  logic rst_n,
    input  logic clk,
    input  logic retire,
    csr_if.bank  bus
);

    // Full 64 bit counters.
    logic [2*`CSR_XLEN-1:0] mcycle;
    logic [2*`CSR_XLEN-1:0] minstret;

    // Machine halves are writable, user aliases only readable.
    always_comb begin
        bus.exists = 1'b1;
        bus.rdonly = 1'b0;
        bus.priv   = csr_pkg::priv_machine;
        case (bus.addr)
            `CSR_ADDR_MCYCLE:    bus.rdata = mcycle[`CSR_XLEN-1:0];
            `CSR_ADDR_MCYCLEH:   bus.rdata = mcycle[2*`CSR_XLEN-1:`CSR_XLEN];
            `CSR_ADDR_MINSTRET:  bus.rdata = minstret[`CSR_XLEN-1:0];
            `CSR_ADDR_MINSTRETH: bus.rdata = minstret[2*`CSR_XLEN-1:`CSR_XLEN];
            `CSR_ADDR_CYCLE: begin
                bus.rdata  = mcycle[`CSR_XLEN-1:0];
                bus.rdonly = 1'b1;
                bus.priv   = csr_pkg::priv_user;
            end
            `CSR_ADDR_INSTRET: begin
                bus.rdata  = minstret[`CSR_XLEN-1:0];
                bus.rdonly = 1'b1;
                bus.priv   = csr_pkg::priv_user;
            end
            default: begin
                bus.rdata  = '0;
                bus.exists = 1'b0;
            end
        endcase
    end

    // A write replaces the increment in its cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (bus.we && bus.addr == `CSR_ADDR_MCYCLE)
                mcycle <= {mcycle[2*`CSR_XLEN-1:`CSR_XLEN], bus.wdata};
            else if (bus.we && bus.addr == `CSR_ADDR_MCYCLEH)
                mcycle <= {bus.wdata, mcycle[`CSR_XLEN-1:0]};
            else
                mcycle <= mcycle + 1'b1;

            if (bus.we && bus.addr == `CSR_ADDR_MINSTRET)
                minstret <= {minstret[2*`CSR_XLEN-1:`CSR_XLEN], bus.wdata};
            else if (bus.we && bus.addr == `CSR_ADDR_MINSTRETH)
                minstret <= {bus.wdata, minstret[`CSR_XLEN-1:0]};
            else if (retire)
                minstret <= minstret + 1'b1;
        end
    end

endmodule

// ==== source/csr_machine_bank.sv ====
// Machine trap CSR bank
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_machine_bank (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] irq_lines,
    csr_if.bank        bus,
    csr_trap_if.bank   trap
);

    // mstatus fields that exist.
    logic               mst_mie;
    logic               mst_mpie;
    csr_pkg::csr_priv_t mst_mpp;

    csr_pkg::csr_word_t mstatus;
    csr_pkg::csr_word_t mie;
    csr_pkg::csr_word_t mtvec;
    csr_pkg::csr_word_t mscratch;
    csr_pkg::csr_word_t mepc;
    csr_pkg::csr_word_t mcause;
    csr_pkg::csr_word_t mip;
    csr_pkg::csr_word_t tvec_base;

    // Assemble mstatus from its fields.
    always_comb begin
        mstatus = '0;
        mstatus[`CSR_MSTATUS_MIE]  = mst_mie;
        mstatus[`CSR_MSTATUS_MPIE] = mst_mpie;
        mstatus[`CSR_MSTATUS_MPP]  = mst_mpp;
    end

    // Software, timer and external lines.
    always_comb begin
        mip     = '0;
        mip[3]  = irq_lines[0];
        mip[7]  = irq_lines[1];
        mip[11] = irq_lines[2];
    end

    // Address decode, all machine level.
    always_comb begin
        bus.exists = 1'b1;
        bus.rdonly = 1'b0;
        bus.priv   = csr_pkg::priv_machine;
        case (bus.addr)
            `CSR_ADDR_MSTATUS:  bus.rdata = mstatus;
            `CSR_ADDR_MIE:      bus.rdata = mie;
            `CSR_ADDR_MTVEC:    bus.rdata = mtvec;
            `CSR_ADDR_MSCRATCH: bus.rdata = mscratch;
            `CSR_ADDR_MEPC:     bus.rdata = mepc;
            `CSR_ADDR_MCAUSE:   bus.rdata = mcause;
            `CSR_ADDR_MIP: begin
                bus.rdata  = mip;
                bus.rdonly = 1'b1;
            end
            default: begin
                bus.rdata  = '0;
                bus.exists = 1'b0;
            end
        endcase
    end

    // Trap first, then mret, then software writes.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mst_mie  <= 1'b0;
            mst_mpie <= 1'b0;
            mst_mpp  <= csr_pkg::priv_user;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (trap.trap) begin
            mepc     <= trap.epc;
            mcause   <= {trap.is_irq, {(`CSR_XLEN-6){1'b0}}, trap.cause};
            mst_mpie <= mst_mie;
            mst_mie  <= 1'b0;
            mst_mpp  <= trap.cur_priv;
        end else if (trap.mret) begin
            mst_mie  <= mst_mpie;
            mst_mpie <= 1'b1;
            mst_mpp  <= csr_pkg::priv_user;
        end else if (bus.we) begin
            case (bus.addr)
                `CSR_ADDR_MSTATUS: begin
                    mst_mie  <= bus.wdata[`CSR_MSTATUS_MIE];
                    mst_mpie <= bus.wdata[`CSR_MSTATUS_MPIE];
                    // Only user and machine are legal in MPP.
                    mst_mpp  <= (bus.wdata[`CSR_MSTATUS_MPP] == 2'b11) ?
                                csr_pkg::priv_machine : csr_pkg::priv_user;
                end
                `CSR_ADDR_MIE:      mie      <= bus.wdata;
                `CSR_ADDR_MTVEC:    mtvec    <= bus.wdata;
                `CSR_ADDR_MSCRATCH: mscratch <= bus.wdata;
                `CSR_ADDR_MEPC:     mepc     <= bus.wdata;
                `CSR_ADDR_MCAUSE:   mcause   <= bus.wdata;
                default: ;
            endcase
        end
    end

    // Handler address, mode in mtvec bit 0.
    // Vectored mode offsets interrupts only.
    assign tvec_base = {mtvec[`CSR_XLEN-1:2], 2'b00};
    assign trap.tvec = (mtvec[0] && trap.is_irq) ?
                       tvec_base + {{(`CSR_XLEN-7){1'b0}}, trap.cause, 2'b00} : tvec_base;

    assign trap.ret_epc     = mepc;
    assign trap.ret_priv    = mst_mpp;
    assign trap.irq_pending = mst_mie && |(mip & mie);

    // Core must not trap and return in one cycle.
    trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap.trap && trap.mret))
        else $error("csr_machine_bank: trap and mret together");

endmodule

// ==== source/csr_access_unit.sv ====
// CSR instruction access unit
`timescale 1ns/100ps

module csr_access_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  csr_pkg::csr_addr_t  req_addr,
    input  csr_pkg::csr_wmode_t req_wmode,
    input  csr_pkg::csr_word_t  req_src,
    input  csr_pkg::csr_priv_t  cur_priv,
    input  logic                flush,
    output logic                resp_valid,
    output logic                resp_illegal,
    output csr_pkg::csr_word_t  resp_rdata,
    csr_if.requester            bus
);

    csr_pkg::csr_word_t wdata;
    logic               wants_write;
    logic               illegal;

    // New value from the write mode.
    always_comb begin
        case (req_wmode)
            csr_pkg::wmode_write: wdata = req_src;
            csr_pkg::wmode_set:   wdata = bus.rdata | req_src;
            csr_pkg::wmode_clear: wdata = bus.rdata & ~req_src;
            default:              wdata = bus.rdata;
        endcase
    end

    // Set and clear with a zero source only read.
    assign wants_write = (req_wmode == csr_pkg::wmode_write) ||
                         (req_wmode != csr_pkg::wmode_none && req_src != '0);

    // Unknown address, too little privilege, or a write to a read-only CSR.
    assign illegal = !bus.exists || (cur_priv < bus.priv) || (wants_write && bus.rdonly);

    // Drive the bus straight from the request.
    assign bus.addr  = req_addr;
    assign bus.wdata = wdata;
    assign bus.we    = req_valid && wants_write && !illegal && !flush;

    // Response appears one cycle after sampling.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid   <= 1'b0;
            resp_illegal <= 1'b0;
        end else begin
            resp_valid   <= req_valid;
            // A trap or mret in the same cycle kills the access.
            resp_illegal <= req_valid && (illegal || flush);
        end
    end

    // Old value, captured before the write lands.
    always_ff @(posedge clk) begin
        resp_rdata <= illegal ? '0 : bus.rdata;
    end

    // Requests always carry a real mode.
    wmode_valid: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> req_wmode != csr_pkg::wmode_none)
        else $error("csr_access_unit: request with write mode none");

endmodule

// ==== source/csr_overlay.sv ====
// CSR bank overlay
`timescale 1ns/100ps

module csr_overlay #(
    parameter int banks = 2
) (
    input  logic      clk,
    csr_if.bank       up,
    csr_if.requester  down [banks]
);

    // Bank hit vector.
    logic [banks-1:0]    sel;
    // Per bank responses, gathered for the encoders.
    logic                rdonly [banks];
    csr_pkg::csr_priv_t  priv [banks];
    csr_pkg::csr_word_t  rdata [banks];

    for (genvar i = 0; i < banks; i++) begin : g_bank
        // Every bank sees the same request.
        assign down[i].we    = up.we;
        assign down[i].addr  = up.addr;
        assign down[i].wdata = up.wdata;

        // Collect the responses.
        assign sel[i]    = down[i].exists;
        assign rdonly[i] = down[i].rdonly;
        assign priv[i]   = down[i].priv;
        assign rdata[i]  = down[i].rdata;
    end

    // Known if any bank claims the address.
    assign up.exists = |sel;

    csr_sel_enc #(.n(banks), .payload_t(logic)) u_rdonly_enc (
        .clk(clk), .sel(sel), .in(rdonly), .out(up.rdonly)
    );
    csr_sel_enc #(.n(banks), .payload_t(csr_pkg::csr_priv_t)) u_priv_enc (
        .clk(clk), .sel(sel), .in(priv), .out(up.priv)
    );
    csr_sel_enc #(.n(banks), .payload_t(csr_pkg::csr_word_t)) u_rdata_enc (
        .clk(clk), .sel(sel), .in(rdata), .out(up.rdata)
    );

endmodule

// ==== source/csr_sel_enc.sv ====
// One-hot select encoder
`timescale 1ns/100ps

module csr_sel_enc #(
    parameter int n = 2,
    parameter type payload_t = logic
) (
    input  logic         clk,
    input  logic [n-1:0] sel,
    input  payload_t     in [n],
    output payload_t     out
);

    // OR of every selected input.
    // Gives zero when no bit of sel is set.
    always_comb begin
        logic [$bits(payload_t)-1:0] acc;
        acc = '0;
        for (int i = 0; i < n; i++) begin
            if (sel[i]) begin
                acc = acc | in[i];
            end
        end
        out = payload_t'(acc);
    end

    // Address decoders of separate banks must never overlap.
    sel_onehot: assert property (@(posedge clk) $onehot0(sel))
        else $error("csr_sel_enc: more than one source selected");

endmodule

// ==== source/csr_if.sv ====
// CSR bus interfaces
`timescale 1ns/100ps

// Single word access bus, zero latency.
interface csr_if;
    // Requester to bank: write strobe.
    logic                 we;
    // Requester to bank: address.
    csr_pkg::csr_addr_t   addr;
    // Requester to bank: data to commit.
    csr_pkg::csr_word_t   wdata;
    // Bank to requester: address decoded.
    logic                 exists;
    // Bank to requester: register cannot be written.
    logic                 rdonly;
    // Bank to requester: lowest privilege allowed.
    csr_pkg::csr_priv_t   priv;
    // Bank to requester: current value.
    csr_pkg::csr_word_t   rdata;

    // Access side.
    modport requester (output we, addr, wdata, input exists, rdonly, priv, rdata);
    // Register side.
    modport bank (input we, addr, wdata, output exists, rdonly, priv, rdata);
endinterface

// Trap entry and return events.
interface csr_trap_if;
    // Core to bank: trap strobe.
    logic                 trap;
    // Core to bank: trap is an interrupt.
    logic                 is_irq;
    // Core to bank: trap cause code.
    csr_pkg::csr_cause_t  cause;
    // Core to bank: pc of the trapping instruction.
    csr_pkg::csr_word_t   epc;
    // Core to bank: mret strobe.
    logic                 mret;
    // Core to bank: privilege at the time of the trap.
    csr_pkg::csr_priv_t   cur_priv;
    // Bank to core: handler address.
    csr_pkg::csr_word_t   tvec;
    // Bank to core: return address.
    csr_pkg::csr_word_t   ret_epc;
    // Bank to core: privilege to return to.
    csr_pkg::csr_priv_t   ret_priv;
    // Bank to core: enabled interrupt waiting.
    logic                 irq_pending;

    modport core (output trap, is_irq, cause, epc, mret, cur_priv,
                  input tvec, ret_epc, ret_priv, irq_pending);
    modport bank (input trap, is_irq, cause, epc, mret, cur_priv,
                  output tvec, ret_epc, ret_priv, irq_pending);
endinterface

// ==== source/csr_pkg.sv ====
// CSR shared types
`include "csr_defs.svh"

package csr_pkg;

    // One data word.
    typedef logic [`CSR_XLEN-1:0] csr_word_t;

    // Twelve bit CSR address.
    typedef logic [11:0] csr_addr_t;

    // Privilege levels.
    // Codes 1 and 2 are not implemented.
    typedef enum logic [1:0] {
        priv_user    = 2'd0,
        priv_machine = 2'd3
    } csr_priv_t;

    // Write mode of a CSR instruction.
    // Encoding follows the funct3 low bits of csrrw/csrrs/csrrc.
    typedef enum logic [1:0] {
        wmode_none  = 2'd0,
        wmode_write = 2'd1,
        wmode_set   = 2'd2,
        wmode_clear = 2'd3
    } csr_wmode_t;

    // Exception or interrupt code.
    typedef logic [4:0] csr_cause_t;

endpackage

// ==== source/csr_defs.svh ====
// CSR subsystem definitions
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data path width.
`define CSR_XLEN 32

// Banks behind the overlay.
`define CSR_NUM_BANKS 2

// Machine trap setup and handling.
`define CSR_ADDR_MSTATUS 12'h300
`define CSR_ADDR_MIE 12'h304
`define CSR_ADDR_MTVEC 12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC 12'h341
`define CSR_ADDR_MCAUSE 12'h342
`define CSR_ADDR_MIP 12'h344

// Machine counters and their user read-only aliases.
`define CSR_ADDR_MCYCLE 12'hB00
`define CSR_ADDR_MINSTRET 12'hB02
`define CSR_ADDR_MCYCLEH 12'hB80
`define CSR_ADDR_MINSTRETH 12'hB82
`define CSR_ADDR_CYCLE 12'hC00
`define CSR_ADDR_INSTRET 12'hC02

// Field positions inside mstatus.
`define CSR_MSTATUS_MIE 3
`define CSR_MSTATUS_MPIE 7
`define CSR_MSTATUS_MPP 12:11

`endif
